// File: hdl/memArbPkg.sv
package memArbPkg;

    // memory geometry
    localparam int BLOCK_BITS = 512;
    localparam int ADDR_BITS = 32;
    localparam int BLOCK_BYTES = 64;
    localparam int BLK_SHIFT = $clog2(BLOCK_BYTES); // byte addr to block number

    // accelerator signal table sizing
    localparam int SIG_COUNT = 8;
    localparam int SIG_IDX_BITS = 3;
    localparam int START_BLK_BITS = 18;             // start block field in table
    localparam int CHUNK_BLOCKS = 4;                // blocks per accel chunk
    localparam int OFF_BITS = $clog2(CHUNK_BLOCKS);

    localparam logic [ADDR_BITS-1:0] SIG_REGION_BASE = 32'h1000_0000;
    localparam logic [ADDR_BITS-1:0] ALIGN_MASK = ~(ADDR_BITS'(BLOCK_BYTES - 1));

    typedef logic [BLOCK_BITS-1:0] block_t;
    typedef logic [ADDR_BITS-1:0] addr_t;

    // controller opcodes, same codes the controller already decodes
    typedef enum logic [1:0] {
        OP_IDLE  = 2'b00,
        OP_READ  = 2'b01,
        OP_WRITE = 2'b11
    } memOp_t;

    // who owns the port
    typedef enum logic [1:0] {
        CL_NONE  = 2'b00,
        CL_INSTR = 2'b01,
        CL_DATA  = 2'b10,
        CL_ACCEL = 2'b11
    } client_t;

    // request toward the memory controller
    typedef struct packed {
        memOp_t op;
        addr_t  addr;
        block_t wrBlk;   // only meaningful on writes
    } memReq_t;

    // decode -> execute
    typedef struct packed {
        client_t client;
        logic    isWrite;
        addr_t   addr;   // already block aligned
    } arbGrant_t;

    // host write port into the signal table
    typedef struct packed {
        logic                      strobe;
        logic [SIG_IDX_BITS-1:0]   idx;
        logic [START_BLK_BITS-1:0] startBlk;
    } sigWrite_t;

endpackage

// File: hdl/sigBlockTable.sv
`timescale 1ns/100ps

module sigBlockTable
    import memArbPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  sigWrite_t               sigWrite,   // host side table write
    input  logic [SIG_IDX_BITS-1:0] sigNum,     // signal the accel is working on
    input  logic                    chunkStep,  // one block of the chunk finished
    output addr_t                   accelAddr,
    output logic                    lastBlock
);

    logic [START_BLK_BITS-1:0] startTbl [SIG_COUNT];
    logic [OFF_BITS-1:0]       blockOffset;
    addr_t                     blkNum;

    // start block entries, host writes one per cycle at most
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < SIG_COUNT; i++) begin
                startTbl[i] <= '0;
            end
        end else if (sigWrite.strobe) begin
            startTbl[sigWrite.idx] <= sigWrite.startBlk;
        end
    end

    assign lastBlock = (blockOffset == OFF_BITS'(CHUNK_BLOCKS - 1));

    // offset within the current chunk
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            blockOffset <= '0;
        end else if (chunkStep) begin
            if (lastBlock) begin
                blockOffset <= '0;              // chunk finished, back to first block
            end else begin
                blockOffset <= blockOffset + 1'b1;
            end
        end
    end

    // block number inside the signal region
    assign blkNum = ADDR_BITS'(startTbl[sigNum]) + ADDR_BITS'(blockOffset);

    // byte address of the block
    assign accelAddr = SIG_REGION_BASE + (blkNum << BLK_SHIFT);

endmodule

// File: hdl/memArbReqDecode.sv
`timescale 1ns/100ps

module memArbReqDecode
    import memArbPkg::*;
(
    input  logic      instrReq,    // icache miss level
    input  addr_t     instrAddr,
    input  logic      dataReq,     // dcache fill level
    input  logic      dataEvict,   // dcache eviction level
    input  addr_t     dataAddr,
    input  logic      accelRd,
    input  logic      accelWr,
    input  addr_t     accelAddr,   // from the signal table
    output arbGrant_t grant
);

    addr_t instrAligned;
    addr_t dataAligned;
    logic  accelAny;
    logic  dataAny;

    // drop the byte offset inside the block
    assign instrAligned = instrAddr & ALIGN_MASK;
    assign dataAligned = dataAddr & ALIGN_MASK;

    assign accelAny = accelRd | accelWr;
    assign dataAny = dataReq | dataEvict;

    // fixed priority, accel first, then dcache, then icache
    always_comb begin
        grant.client = CL_NONE;
        grant.isWrite = 1'b0;
        grant.addr = '0;

        if (accelAny) begin
            grant.client = CL_ACCEL;
            grant.isWrite = ~accelRd;         // read wins if both are up
            grant.addr = accelAddr;           // table address is block aligned already
        end else if (dataAny) begin
            grant.client = CL_DATA;
            grant.isWrite = dataEvict;        // evict goes out before the fill
            grant.addr = dataAligned;
        end else if (instrReq) begin
            grant.client = CL_INSTR;
            grant.isWrite = 1'b0;             // icache never writes
            grant.addr = instrAligned;
        end
    end

endmodule

// File: hdl/memArbTransferFsm.sv
`timescale 1ns/100ps

module memArbTransferFsm
    import memArbPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  arbGrant_t grant,
    input  block_t    accelWrBlk,
    input  block_t    dataWrBlk,
    input  logic      txDone,             // controller accepted the request
    input  logic      respDone,           // read block delivered by result stage
    input  logic      lastBlock,
    input  addr_t     accelAddr,
    output memReq_t   memReq,
    output client_t   respClient,
    output logic      chunkStep,
    output logic      evictAck,
    output logic      accelWrDone,
    output logic      transformComplete
);

    typedef enum logic [1:0] {
        ST_IDLE    = 2'b00,
        ST_REQ     = 2'b01,   // op held on the controller port
        ST_WAIT_RD = 2'b10,   // waiting for the read block
        ST_WR_DONE = 2'b11    // write acknowledged, one cycle
    } state_t;

    state_t  state, nextState;
    client_t curClient;
    logic    curWrite;
    addr_t   reqAddr;          // cache address of the granted request
    logic    startXfer;
    logic    blkDone;
    logic    moreBlocks;

    assign startXfer = (state == ST_IDLE) && (grant.client != CL_NONE);

    // a block finished, read delivered or write acked
    assign blkDone = ((state == ST_WAIT_RD) && respDone) || (state == ST_WR_DONE);
    assign moreBlocks = (curClient == CL_ACCEL) && !lastBlock;

    always_comb begin
        nextState = state;
        case (state)
            ST_IDLE: begin
                if (startXfer) nextState = ST_REQ;
            end
            ST_REQ: begin
                if (txDone) nextState = curWrite ? ST_WR_DONE : ST_WAIT_RD;
            end
            ST_WAIT_RD: begin
                if (respDone) nextState = moreBlocks ? ST_REQ : ST_IDLE;
            end
            ST_WR_DONE: begin
                nextState = moreBlocks ? ST_REQ : ST_IDLE;  // chunk loops without idle
            end
            default: nextState = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            curClient <= CL_NONE;
            curWrite <= 1'b0;
        end else begin
            state <= nextState;
            if (startXfer) begin
                curClient <= grant.client;   // grant frozen for the whole transfer
                curWrite <= grant.isWrite;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startXfer) reqAddr <= grant.addr;
    end

    // controller port, only active while in ST_REQ
    always_comb begin
        memReq.op = OP_IDLE;
        memReq.addr = '0;
        memReq.wrBlk = '0;
        if (state == ST_REQ) begin
            memReq.op = curWrite ? OP_WRITE : OP_READ;
            // accel address follows the table offset block by block
            memReq.addr = (curClient == CL_ACCEL) ? accelAddr : reqAddr;
            if (curWrite) begin
                memReq.wrBlk = (curClient == CL_ACCEL) ? accelWrBlk : dataWrBlk;
            end
        end
    end

    // result stage only cares while a read is outstanding
    assign respClient = ((state == ST_REQ || state == ST_WAIT_RD) && !curWrite)
                      ? curClient : CL_NONE;

    assign chunkStep = blkDone && (curClient == CL_ACCEL);
    assign transformComplete = chunkStep && lastBlock;   // lines up with last done pulse

    assign evictAck = (state == ST_WR_DONE) && (curClient == CL_DATA);
    assign accelWrDone = (state == ST_WR_DONE) && (curClient == CL_ACCEL);

endmodule

// File: hdl/memArbRespRoute.sv
`timescale 1ns/100ps

module memArbRespRoute
    import memArbPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  client_t respClient,   // who the outstanding read belongs to
    input  logic    rdValid,
    input  block_t  rdBlk,
    output block_t  instrBlk,
    output logic    instrValid,
    output block_t  dataBlk,
    output logic    dataValid,
    output block_t  accelBlk,
    output logic    accelRdDone,
    output logic    respDone      // back to execute
);

    logic rdHit;

    // stray rdValid with nobody waiting is ignored
    assign rdHit = rdValid && (respClient != CL_NONE);

    // one cycle pulses, edge after rdValid
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            instrValid <= 1'b0;
            dataValid <= 1'b0;
            accelRdDone <= 1'b0;
            respDone <= 1'b0;
        end else begin
            instrValid <= rdHit && (respClient == CL_INSTR);
            dataValid <= rdHit && (respClient == CL_DATA);
            accelRdDone <= rdHit && (respClient == CL_ACCEL);
            respDone <= rdHit;
        end
    end

    // block payloads, only the owner's copy changes
    always_ff @(posedge clk) begin
        if (rdHit) begin
            case (respClient)
                CL_INSTR: instrBlk <= rdBlk;
                CL_DATA:  dataBlk <= rdBlk;
                CL_ACCEL: accelBlk <= rdBlk;
                default:  ;                  // CL_NONE filtered by rdHit
            endcase
        end
    end

endmodule

// File: hdl/memArbTop.sv
`timescale 1ns/100ps

module memArbTop
    import memArbPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    // icache
    input  logic                    instrReq,
    input  addr_t                   instrAddr,
    output block_t                  instrBlk,
    output logic                    instrValid,

    // dcache
    input  logic                    dataReq,
    input  logic                    dataEvict,
    input  addr_t                   dataAddr,
    input  block_t                  dataWrBlk,
    output block_t                  dataBlk,
    output logic                    dataValid,
    output logic                    evictAck,

    // accelerator buffer
    input  logic                    accelRd,
    input  logic                    accelWr,
    input  logic [SIG_IDX_BITS-1:0] sigNum,
    input  block_t                  accelWrBlk,
    output block_t                  accelBlk,
    output logic                    accelRdDone,
    output logic                    accelWrDone,
    output logic                    transformComplete,

    // host table writes
    input  sigWrite_t               sigWrite,

    // memory controller
    output memReq_t                 memReq,
    input  logic                    txDone,
    input  logic                    rdValid,
    input  block_t                  rdBlk
);

    arbGrant_t grant;
    addr_t     accelAddr;
    logic      chunkStep;
    logic      lastBlock;
    logic      respDone;
    client_t   respClient;

    memArbReqDecode i_decode (
        .instrReq (instrReq),
        .instrAddr(instrAddr),
        .dataReq  (dataReq),
        .dataEvict(dataEvict),
        .dataAddr (dataAddr),
        .accelRd  (accelRd),
        .accelWr  (accelWr),
        .accelAddr(accelAddr),
        .grant    (grant)
    );

    sigBlockTable i_sigTable (
        .clk      (clk),
        .rst      (rst),
        .sigWrite (sigWrite),
        .sigNum   (sigNum),
        .chunkStep(chunkStep),
        .accelAddr(accelAddr),
        .lastBlock(lastBlock)
    );

    memArbTransferFsm i_xferFsm (
        .clk              (clk),
        .rst              (rst),
        .grant            (grant),
        .accelWrBlk       (accelWrBlk),
        .dataWrBlk        (dataWrBlk),
        .txDone           (txDone),
        .respDone         (respDone),
        .lastBlock        (lastBlock),
        .accelAddr        (accelAddr),
        .memReq           (memReq),
        .respClient       (respClient),
        .chunkStep        (chunkStep),
        .evictAck         (evictAck),
        .accelWrDone      (accelWrDone),
        .transformComplete(transformComplete)
    );

    memArbRespRoute i_respRoute (
        .clk        (clk),
        .rst        (rst),
        .respClient (respClient),
        .rdValid    (rdValid),
        .rdBlk      (rdBlk),
        .instrBlk   (instrBlk),
        .instrValid (instrValid),
        .dataBlk    (dataBlk),
        .dataValid  (dataValid),
        .accelBlk   (accelBlk),
        .accelRdDone(accelRdDone),
        .respDone   (respDone)
    );

endmodule

// File: tests/memCtrlModel.sv
`timescale 1ns/100ps

module memCtrlModel
    import memArbPkg::*;
(
    input  logic    clk,
    input  memReq_t memReq,
    output logic    txDone,
    output logic    rdValid,
    output block_t  rdBlk
);

    localparam int STORE_DEPTH = 32;   // distinct written blocks kept
    localparam int DRV_DLY = 5;        // ns after the rising edge

    addr_t   storeAddr [STORE_DEPTH];
    block_t  storeData [STORE_DEPTH];
    int      storeCount;
    int      idx;
    int      lat;
    integer  seed;
    memReq_t held;                     // request as seen on txDone

    // untouched blocks read as a pattern of their own address
    function automatic block_t presetBlock(input addr_t blkAddr);
        block_t blk;
        for (int w = 0; w < BLOCK_BITS / 32; w++) begin
            blk[w*32 +: 32] = blkAddr ^ (32'(w) * 32'h1357_9bdf);
        end
        return blk;
    endfunction

    function automatic int findBlock(input addr_t blkAddr);
        for (int i = 0; i < storeCount; i++) begin
            if (storeAddr[i] == blkAddr) return i;
        end
        return -1;
    endfunction

    initial begin
        seed = 32'he000_54b7;
        storeCount = 0;
        txDone = 1'b0;
        rdValid = 1'b0;
        rdBlk = '0;
        forever begin
            @(posedge clk);
            #DRV_DLY;
            if (memReq.op != OP_IDLE) begin
                lat = {$random(seed)} % 4;    // request held 1 to 4 cycles
                repeat (lat) begin
                    @(posedge clk);
                    #DRV_DLY;
                end
                held = memReq;
                txDone = 1'b1;
                @(posedge clk);
                #DRV_DLY;
                txDone = 1'b0;
                idx = findBlock(held.addr);
                if (held.op == OP_WRITE) begin
                    if (idx < 0 && storeCount < STORE_DEPTH) begin
                        idx = storeCount;     // new entry
                        storeCount++;
                    end
                    storeAddr[idx] = held.addr;
                    storeData[idx] = held.wrBlk;
                end else begin
                    rdBlk = (idx >= 0) ? storeData[idx] : presetBlock(held.addr);
                    rdValid = 1'b1;           // block one cycle after txDone
                    @(posedge clk);
                    #DRV_DLY;
                    rdValid = 1'b0;
                end
            end
        end
    end

endmodule

// File: tests/memArbTb.sv
`timescale 1ns/100ps

module memArbTb
    import memArbPkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int DRV_DLY = 5;        // input drive point after the edge
    localparam int NUM_ROWS = 6;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * CHUNK_BLOCKS * 20;

    // request levels of one test step and what should come back
    typedef struct packed {
        logic                      setSig;       // host table write first
        logic [START_BLK_BITS-1:0] startBlk;
        logic [SIG_IDX_BITS-1:0]   sig;
        logic                      instrReq;
        logic                      dataReq;
        logic                      dataEvict;
        logic                      accelRd;
        logic                      accelWr;
        logic                      accelFromWr;  // accel read expects written blocks
        addr_t                     instrAddr;
        addr_t                     dataAddr;
        block_t                    wrBlk;        // accel block k is wrBlk + k
        block_t                    expInstr;
        block_t                    expData;
    } stimRow_t;

    logic clk, rst;
    logic instrReq, instrValid;
    logic dataReq, dataEvict, dataValid, evictAck;
    logic accelRd, accelWr, accelRdDone, accelWrDone, transformComplete;
    logic txDone, rdValid;
    logic [SIG_IDX_BITS-1:0] sigNum;
    addr_t     instrAddr, dataAddr;
    block_t    instrBlk, dataBlk, dataWrBlk, accelWrBlk, accelBlk, rdBlk;
    sigWrite_t sigWrite;
    memReq_t   memReq;

    stimRow_t rows [NUM_ROWS];
    integer   seed;
    int       curRow;

    memArbTop i_dut (.*);
    memCtrlModel i_memCtrl (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // preset rule of the controller model keyed by aligned address
    function automatic block_t patternBlock(input addr_t blkAddr);
        block_t blk;
        for (int w = 0; w < BLOCK_BITS / 32; w++) begin
            blk[w*32 +: 32] = blkAddr ^ (32'(w) * 32'h1357_9bdf);
        end
        return blk;
    endfunction

    // byte address of block k of a signal chunk
    function automatic addr_t chunkAddr(input logic [START_BLK_BITS-1:0] startBlk, input int k);
        return SIG_REGION_BASE + ADDR_BITS'((int'(startBlk) + k) * BLOCK_BYTES);
    endfunction

    task automatic randomBlock(output block_t blk);
        for (int w = 0; w < BLOCK_BITS / 32; w++) begin
            blk[w*32 +: 32] = $random(seed);
        end
    endtask

    task automatic failCheck(input string msg);
        $display("[ERROR] %0t: row %0d, %s", $time, curRow, msg);
        $display("Errors found");
        $fatal(1, "stopped at first failed check");
    endtask

    task automatic loadTable();
        block_t wb;
        foreach (rows[i]) rows[i] = '0;
        rows[0].instrReq = 1'b1;                  // unaligned fetch
        rows[0].instrAddr = 32'h0000_1234;
        rows[0].expInstr = patternBlock(32'h0000_1200);
        randomBlock(wb);
        rows[1].dataEvict = 1'b1;                 // evict then refill same line
        rows[1].dataReq = 1'b1;
        rows[1].dataAddr = 32'h0000_2a48;
        rows[1].wrBlk = wb;
        rows[1].expData = wb;
        rows[2].setSig = 1'b1;                    // fresh signal read back as pattern blocks
        rows[2].sig = 3'd2;
        rows[2].startBlk = 18'h00040;
        rows[2].accelRd = 1'b1;
        randomBlock(wb);
        rows[3].setSig = 1'b1;                    // write chunk of signal 5
        rows[3].sig = 3'd5;
        rows[3].startBlk = 18'h00100;
        rows[3].accelWr = 1'b1;
        rows[3].wrBlk = wb;
        rows[4] = rows[3];                        // read it back
        rows[4].setSig = 1'b0;
        rows[4].accelWr = 1'b0;
        rows[4].accelRd = 1'b1;
        rows[4].accelFromWr = 1'b1;
        rows[5] = rows[2];                        // all three clients at once
        rows[5].setSig = 1'b0;
        rows[5].dataReq = 1'b1;
        rows[5].dataAddr = 32'h0000_4010;
        rows[5].expData = patternBlock(32'h0000_4000);
        rows[5].instrReq = 1'b1;
        rows[5].instrAddr = 32'h0000_303c;
        rows[5].expInstr = patternBlock(32'h0000_3000);
    endtask

    // port idle and no pulse high
    task automatic checkQuiet(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #DRV_DLY;
            assert (memReq.op == OP_IDLE && !instrValid && !dataValid && !evictAck
                    && !accelRdDone && !accelWrDone && !transformComplete)
            else failCheck("arbiter not quiet while no request is pending");
        end
    endtask

    task automatic runRow(input stimRow_t r);
        int     accelCnt;
        block_t expAccel;
        accelCnt = 0;
        if (r.setSig) begin
            sigWrite = '{strobe: 1'b1, idx: r.sig, startBlk: r.startBlk};
            @(posedge clk);
            #DRV_DLY;
            sigWrite = '0;
        end
        sigNum = r.sig;
        instrAddr = r.instrAddr;
        dataAddr = r.dataAddr;
        // write port of the client not writing holds the inverse block
        dataWrBlk = r.dataEvict ? r.wrBlk : ~r.wrBlk;
        accelWrBlk = r.accelWr ? r.wrBlk : ~r.wrBlk;
        {instrReq, dataReq, dataEvict} = {r.instrReq, r.dataReq, r.dataEvict};
        {accelRd, accelWr} = {r.accelRd, r.accelWr};
        while (instrReq || dataReq || dataEvict || accelRd || accelWr) begin
            @(posedge clk);
            #DRV_DLY;
            // accel owns the port while its level is up
            if (memReq.op != OP_IDLE && (accelRd || accelWr)) begin
                assert (memReq.addr == chunkAddr(r.startBlk, accelCnt))
                else failCheck("accel block address wrong");
            end
            if (evictAck) begin
                assert (dataEvict && !accelRd && !accelWr) else failCheck("evictAck out of order");
                dataEvict = 1'b0;
            end
            if (dataValid) begin
                assert (dataReq && !dataEvict && !accelRd && !accelWr)
                else failCheck("dataValid out of order");
                assert (dataBlk == r.expData) else failCheck("dataBlk mismatch");
                dataReq = 1'b0;
            end
            if (instrValid) begin
                assert (instrReq && !dataReq && !dataEvict && !accelRd && !accelWr)
                else failCheck("instrValid out of order");
                assert (instrBlk == r.expInstr) else failCheck("instrBlk mismatch");
                instrReq = 1'b0;
            end
            if (accelRdDone || accelWrDone) begin
                assert (accelRdDone ? accelRd : accelWr) else failCheck("stray accel done");
                if (accelRdDone) begin
                    expAccel = r.accelFromWr ? r.wrBlk + block_t'(accelCnt)
                                             : patternBlock(chunkAddr(r.startBlk, accelCnt));
                    assert (accelBlk == expAccel) else failCheck("accelBlk mismatch");
                end
                accelCnt++;
                accelWrBlk = r.wrBlk + block_t'(accelCnt);   // next block of the chunk
                assert (transformComplete == (accelCnt == CHUNK_BLOCKS))
                else failCheck("transformComplete not on the last block");
                if (transformComplete) begin
                    accelRd = 1'b0;
                    accelWr = 1'b0;
                end
            end else begin
                assert (!transformComplete) else failCheck("transformComplete without done");
            end
        end
        checkQuiet(3);                            // catches extra pulses too
    endtask

    initial begin
        seed = 32'he000_54b7;
        rst = 1'b1;
        curRow = -1;
        {instrReq, dataReq, dataEvict, accelRd, accelWr} = '0;
        instrAddr = '0;
        dataAddr = '0;
        dataWrBlk = '0;
        accelWrBlk = '0;
        sigNum = '0;
        sigWrite = '0;
        loadTable();
        repeat (4) @(posedge clk);
        #DRV_DLY;
        rst = 1'b0;
        checkQuiet(4);                            // idle state out of reset
        for (int i = 0; i < NUM_ROWS; i++) begin
            curRow = i;
            runRow(rows[i]);
        end
        $display("No errors");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: memArbiter.f
hdl/memArbPkg.sv
hdl/sigBlockTable.sv
hdl/memArbReqDecode.sv
hdl/memArbTransferFsm.sv
hdl/memArbRespRoute.sv
hdl/memArbTop.sv
tests/memCtrlModel.sv
tests/memArbTb.sv
